// File: scan_defines.svh
`ifndef SCAN_DEFINES_SVH
`define SCAN_DEFINES_SVH

// Automaton state word width
`define SCAN_STATE_W 11

// Stream id width and number of streams
`define SCAN_STREAM_W 6
`define SCAN_NUM_STREAMS 64

// Global match counter width
`define SCAN_COUNT_W 16

// Keyword length in bytes
`define SCAN_KEY_LEN 6

// Keyword bytes of "finger"
`define SCAN_KEY_0 8'h66
`define SCAN_KEY_1 8'h69
`define SCAN_KEY_2 8'h6e
`define SCAN_KEY_3 8'h67
`define SCAN_KEY_4 8'h65
`define SCAN_KEY_5 8'h72

`endif

// File: scan_pkg.sv
`include "scan_defines.svh"

package scan_pkg;

  // Automaton state
  // Number of keyword bytes matched so far, SCAN_KEY_LEN means accept
  typedef logic [`SCAN_STATE_W-1:0] dfa_state_t;

  // Stream index
  // Selects one entry of the state memory and the enable table
  typedef logic [`SCAN_STREAM_W-1:0] stream_id_t;

  // Global match count
  // Wraps on overflow
  typedef logic [`SCAN_COUNT_W-1:0] match_count_t;

endpackage

// File: keyword_dfa.sv
`timescale 1ns/10ps

`include "scan_defines.svh"

module keyword_dfa (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           char_in,
  input  logic                 char_in_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic                 state_in_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic                 accept_out
);

  // Accept state value
  localparam scan_pkg::dfa_state_t ACCEPT_STATE = `SCAN_KEY_LEN;

  // Current automaton state
  scan_pkg::dfa_state_t state_q;
  // State the next byte steps from
  scan_pkg::dfa_state_t step_base;
  // State after the byte
  scan_pkg::dfa_state_t step_next;
  // Keyword byte expected next
  logic [7:0]           expect_byte;

  always_comb
  begin
    // A restore arriving with a byte is applied first
    if (state_in_vld)
      step_base = state_in;
    else
      step_base = state_q;
    // After accept the search starts over
    if (step_base == ACCEPT_STATE)
      step_base = '0;
  end

  // Next keyword byte for the current match depth
  always_comb
  begin
    case (step_base)
      scan_pkg::dfa_state_t'(0): expect_byte = `SCAN_KEY_0;
      scan_pkg::dfa_state_t'(1): expect_byte = `SCAN_KEY_1;
      scan_pkg::dfa_state_t'(2): expect_byte = `SCAN_KEY_2;
      scan_pkg::dfa_state_t'(3): expect_byte = `SCAN_KEY_3;
      scan_pkg::dfa_state_t'(4): expect_byte = `SCAN_KEY_4;
      scan_pkg::dfa_state_t'(5): expect_byte = `SCAN_KEY_5;
      default:                   expect_byte = `SCAN_KEY_0;
    endcase
  end

  always_comb
  begin
    // Match extends by one byte
    if (char_in == expect_byte)
      step_next = step_base + scan_pkg::dfa_state_t'(1);
    // Mismatch on a leading "f" restarts at depth one
    else if (char_in == `SCAN_KEY_0)
      step_next = scan_pkg::dfa_state_t'(1);
    else
      step_next = '0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= '0;
    else if (char_in_vld)
      state_q <= step_next;
    else if (state_in_vld)
      state_q <= state_in;
  end

  assign state_out  = state_q;
  assign accept_out = (state_q == ACCEPT_STATE);

  // Automaton state stays within the keyword depth
  a_state_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q <= ACCEPT_STATE
  ) else $error("keyword_dfa: state above accept");

endmodule

// File: stream_matcher.sv
`timescale 1ns/10ps

`include "scan_defines.svh"

module stream_matcher (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   eop,
  input  logic                   load_state,
  input  logic [7:0]             char_in,
  input  logic                   char_in_vld,
  input  logic                   enable,
  input  logic                   new_stream_id,
  input  scan_pkg::stream_id_t   stream_id,
  input  scan_pkg::dfa_state_t   state_out,
  input  logic                   accept_out,
  output logic [7:0]             dfa_char,
  output logic                   dfa_char_vld,
  output scan_pkg::dfa_state_t   dfa_state,
  output logic                   dfa_state_vld,
  output scan_pkg::match_count_t count,
  output logic                   fired
);

  // Saved automaton state per stream
  scan_pkg::dfa_state_t state_mem [`SCAN_NUM_STREAMS];

  // First restore stage
  scan_pkg::dfa_state_t fetch_state;
  logic                 fetch_vld;

  // Registered DFA outputs
  scan_pkg::dfa_state_t state_out_r;
  logic                 accept_out_r;

  // DFA consumed a byte on the last edge
  logic                 step_vld_r;
  // accept_out_r belongs to a consumed byte
  logic                 hit_vld_r;
  logic                 hit;

  // Sticky per-packet match flag
  logic                 fired_q;

  // Restore fetch
  // New streams start from zero, known ones from memory
  always_ff @(posedge clk)
  begin
    if (load_state)
    begin
      if (new_stream_id)
        fetch_state <= '0;
      else
        fetch_state <= state_mem[stream_id];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      fetch_vld <= 1'b0;
    else
      fetch_vld <= load_state;
  end

  // DFA input registers
  always_ff @(posedge clk)
  begin
    dfa_char  <= char_in;
    dfa_state <= fetch_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dfa_char_vld  <= 1'b0;
      dfa_state_vld <= 1'b0;
    end
    else
    begin
      dfa_char_vld  <= char_in_vld;
      dfa_state_vld <= fetch_vld;
    end
  end

  // DFA output registers
  always_ff @(posedge clk)
  begin
    state_out_r  <= state_out;
    accept_out_r <= accept_out;
  end

  // Valid pipeline alongside the byte
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      step_vld_r <= 1'b0;
      hit_vld_r  <= 1'b0;
    end
    else
    begin
      step_vld_r <= dfa_char_vld;
      hit_vld_r  <= step_vld_r;
    end
  end

  // Accept caused by a byte of this packet
  // a restored accept state does not count again
  assign hit   = accept_out_r & hit_vld_r;
  assign fired = fired_q | hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count   <= '0;
      fired_q <= 1'b0;
    end
    else
    begin
      // New packet starts with a clear flag
      if (load_state)
        fired_q <= 1'b0;
      else if (hit)
        fired_q <= 1'b1;
      // Close the packet
      if (eop)
      begin
        if (enable)
          count <= count + scan_pkg::match_count_t'(fired);
        else
          fired_q <= 1'b0;
      end
    end
  end

  // Save state only for enabled streams
  always_ff @(posedge clk)
  begin
    if (eop && enable)
      state_mem[stream_id] <= state_out_r;
  end

  // End of packet is a strobe of its own
  a_eop_alone: assert property (
    @(posedge clk) disable iff (!rst_n)
    eop |-> !load_state && !char_in_vld
  ) else $error("stream_matcher: eop with load_state or byte");

  // Last byte must reach state_out_r before eop saves it
  a_eop_spacing: assert property (
    @(posedge clk) disable iff (!rst_n)
    char_in_vld |=> !eop ##1 !eop
  ) else $error("stream_matcher: eop too close to last byte");

endmodule

// File: stream_enable_regs.sv
`timescale 1ns/10ps

`include "scan_defines.svh"

module stream_enable_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cfg_wr,
  input  scan_pkg::stream_id_t cfg_stream,
  input  logic                 cfg_enable,
  input  scan_pkg::stream_id_t stream_id,
  output logic                 enable
);

  // One enable bit per stream
  logic [`SCAN_NUM_STREAMS-1:0] enable_bits;

  // Host write of a single bit
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      enable_bits <= '0;
    else if (cfg_wr)
      enable_bits[cfg_stream] <= cfg_enable;
  end

  // Bit of the active stream
  assign enable = enable_bits[stream_id];

  // Write address must be known
  a_cfg_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_wr |-> !$isunknown(cfg_stream)
  ) else $error("stream_enable_regs: unknown cfg_stream on write");

endmodule

// File: stream_scanner_top.sv
`timescale 1ns/10ps

module stream_scanner_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [7:0]             char_in,
  input  logic                   char_in_vld,
  input  logic                   load_state,
  input  logic                   new_stream_id,
  input  scan_pkg::stream_id_t   stream_id,
  input  logic                   eop,
  input  logic                   cfg_wr,
  input  scan_pkg::stream_id_t   cfg_stream,
  input  logic                   cfg_enable,
  output scan_pkg::match_count_t count,
  output logic                   fired
);

  // Enable of the active stream
  logic                 enable;

  // Registered DFA inputs
  logic [7:0]           dfa_char;
  logic                 dfa_char_vld;
  scan_pkg::dfa_state_t dfa_state;
  logic                 dfa_state_vld;

  // DFA results
  scan_pkg::dfa_state_t state_out;
  logic                 accept_out;

  stream_enable_regs i_enable_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_stream (cfg_stream),
    .cfg_enable (cfg_enable),
    .stream_id  (stream_id),
    .enable     (enable)
  );

  stream_matcher i_matcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .eop           (eop),
    .load_state    (load_state),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .enable        (enable),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .state_out     (state_out),
    .accept_out    (accept_out),
    .dfa_char      (dfa_char),
    .dfa_char_vld  (dfa_char_vld),
    .dfa_state     (dfa_state),
    .dfa_state_vld (dfa_state_vld),
    .count         (count),
    .fired         (fired)
  );

  keyword_dfa i_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (dfa_char),
    .char_in_vld  (dfa_char_vld),
    .state_in     (dfa_state),
    .state_in_vld (dfa_state_vld),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

endmodule

// File: tb_stream_scanner.sv
`timescale 1ns/10ps

`include "scan_defines.svh"

module tb_stream_scanner;

  // Clock period and watchdog budget
  localparam int CLK_PERIOD   = 100;
  localparam int NUM_PACKETS  = 64;
  localparam int MAX_PKT_LEN  = 60;
  localparam int RESET_MARGIN = 20;
  localparam int WATCHDOG_NS  = NUM_PACKETS * (MAX_PKT_LEN + 10) * CLK_PERIOD
                                + RESET_MARGIN * CLK_PERIOD;

  // DUT ports
  logic                   clk;
  logic                   rst_n;
  logic [7:0]             char_in;
  logic                   char_in_vld;
  logic                   load_state;
  logic                   new_stream_id;
  scan_pkg::stream_id_t   stream_id;
  logic                   eop;
  logic                   cfg_wr;
  scan_pkg::stream_id_t   cfg_stream;
  logic                   cfg_enable;
  scan_pkg::match_count_t count;
  logic                   fired;

  // Reference model, per stream and for the open packet
  scan_pkg::dfa_state_t   m_state [`SCAN_NUM_STREAMS];
  logic                   m_saved [`SCAN_NUM_STREAMS];
  logic                   m_enable [`SCAN_NUM_STREAMS];
  scan_pkg::dfa_state_t   m_cur;
  logic                   m_flag;
  scan_pkg::match_count_t m_count;
  scan_pkg::stream_id_t   m_sid;

  // Expected values, driven in step with the stimulus
  scan_pkg::match_count_t exp_count;
  logic                   exp_flag;
  logic                   exp_hold;
  // Byte strobe and expected flag delayed to the fired check
  logic [2:0]             byte_pipe = '0;
  logic [2:0]             flag_pipe = '0;

  logic [7:0]  key_bytes [`SCAN_KEY_LEN] = '{`SCAN_KEY_0, `SCAN_KEY_1, `SCAN_KEY_2,
                                            `SCAN_KEY_3, `SCAN_KEY_4, `SCAN_KEY_5};
  string       filler_letters = "efginrx";
  logic [31:0] lfsr_q = 32'd75763;
  logic [7:0]  pkt_q [$];

  // Bookkeeping for the report
  int          error_count = 0;
  int          test_num = 0;
  int          tests_failed = 0;
  int          test_err_start = 0;
  string       test_name;

  stream_scanner_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_in_vld   (char_in_vld),
    .load_state    (load_state),
    .new_stream_id (new_stream_id),
    .stream_id     (stream_id),
    .eop           (eop),
    .cfg_wr        (cfg_wr),
    .cfg_stream    (cfg_stream),
    .cfg_enable    (cfg_enable),
    .count         (count),
    .fired         (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  // Fired lags the byte by three edges
  always @(posedge clk)
  begin
    byte_pipe <= {byte_pipe[1:0], char_in_vld};
    flag_pipe <= {flag_pipe[1:0], exp_flag};
  end

  // Outputs idle right after reset
  a_reset_count: assert property (@(posedge clk) $rose(rst_n) |-> (count == '0))
  else
  begin
    error_count++;
    $display("FAILED count after reset: got 0x%h expected 0x0", $sampled(count));
  end

  a_reset_fired: assert property (@(posedge clk) $rose(rst_n) |-> !fired)
  else
  begin
    error_count++;
    $display("FAILED fired after reset: got 0x%h expected 0x0", $sampled(fired));
  end

  // Count settles on the edge after eop
  a_count_eop: assert property (
    @(posedge clk) disable iff (!rst_n) eop |=> (count == exp_count))
  else
  begin
    error_count++;
    $display("FAILED count: got 0x%h expected 0x%h", $sampled(count), $sampled(exp_count));
  end

  // Flag held or cleared by eop
  a_fired_eop: assert property (
    @(posedge clk) disable iff (!rst_n) eop |=> (fired == exp_hold))
  else
  begin
    error_count++;
    $display("FAILED fired after eop: got 0x%h expected 0x%h",
             $sampled(fired), $sampled(exp_hold));
  end

  a_fired_byte: assert property (
    @(posedge clk) disable iff (!rst_n) byte_pipe[2] |-> (fired == flag_pipe[2]))
  else
  begin
    error_count++;
    $display("FAILED fired after byte: got 0x%h expected 0x%h",
             $sampled(fired), $sampled(flag_pipe[2]));
  end

  // Galois step, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Keyword rule: extend on the next byte, else restart on "f"
  function automatic scan_pkg::dfa_state_t model_step(input scan_pkg::dfa_state_t s,
                                                      input logic [7:0] b);
    scan_pkg::dfa_state_t base;
    // Accept behaves like the empty match
    base = (s == `SCAN_KEY_LEN) ? '0 : s;
    if (b == key_bytes[base])
      return base + 1'b1;
    else if (b == key_bytes[0])
      return scan_pkg::dfa_state_t'(1);
    else
      return '0;
  endfunction

  task automatic add_text(input string s);
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
  endtask

  task automatic add_filler(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      draw_bits(3, r);
      pkt_q.push_back(filler_letters[r % 7]);
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    char_in_vld <= 1'b0;
    load_state  <= 1'b0;
    eop         <= 1'b0;
    cfg_wr      <= 1'b0;
  endtask

  task automatic cfg_write(input scan_pkg::stream_id_t sid, input logic en);
    @(posedge clk);
    cfg_wr      <= 1'b1;
    cfg_stream  <= sid;
    cfg_enable  <= en;
    char_in_vld <= 1'b0;
    load_state  <= 1'b0;
    eop         <= 1'b0;
    m_enable[sid] = en;
  endtask

  // Open a packet, new streams start from zero
  task automatic start_packet(input scan_pkg::stream_id_t sid, input logic is_new);
    @(posedge clk);
    load_state    <= 1'b1;
    stream_id     <= sid;
    new_stream_id <= is_new;
    char_in_vld   <= 1'b0;
    eop           <= 1'b0;
    cfg_wr        <= 1'b0;
    m_sid  = sid;
    m_cur  = is_new ? '0 : m_state[sid];
    m_flag = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    char_in     <= b;
    char_in_vld <= 1'b1;
    load_state  <= 1'b0;
    eop         <= 1'b0;
    cfg_wr      <= 1'b0;
    m_cur = model_step(m_cur, b);
    if (m_cur == `SCAN_KEY_LEN)
      m_flag = 1'b1;
    exp_flag <= m_flag;
  endtask

  // Close the packet, only enabled streams count and save
  task automatic end_packet();
    @(posedge clk);
    eop         <= 1'b1;
    char_in_vld <= 1'b0;
    load_state  <= 1'b0;
    cfg_wr      <= 1'b0;
    if (m_enable[m_sid])
    begin
      m_count = m_count + m_flag;
      m_state[m_sid] = m_cur;
      m_saved[m_sid] = 1'b1;
    end
    else
      m_flag = 1'b0;
    exp_count <= m_count;
    exp_hold  <= m_flag;
  endtask

  // Send the queued payload with random gaps
  task automatic run_packet(input scan_pkg::stream_id_t sid, input logic is_new);
    logic [31:0] gap;
    start_packet(sid, is_new);
    while (pkt_q.size() > 0)
    begin
      draw_bits(2, gap);
      if (gap == 0)
        drive_idle();
      send_byte(pkt_q.pop_front());
    end
    // Last byte needs three edges before eop
    drive_idle();
    drive_idle();
    end_packet();
    drive_idle();
  endtask

  task automatic test_begin(input string name);
    test_num++;
    test_name      = name;
    test_err_start = error_count;
  endtask

  task automatic test_end();
    // Let pending checks complete
    repeat (4) drive_idle();
    if (error_count == test_err_start)
      $display("Test %0d %s: passed", test_num, test_name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", test_num, test_name,
               error_count - test_err_start);
    end
  endtask

  initial
  begin
    logic [31:0]          r;
    scan_pkg::stream_id_t sid;
    logic                 is_new;
    rst_n         = 1'b0;
    char_in       = '0;
    char_in_vld   = 1'b0;
    load_state    = 1'b0;
    new_stream_id = 1'b0;
    stream_id     = '0;
    eop           = 1'b0;
    cfg_wr        = 1'b0;
    cfg_stream    = '0;
    cfg_enable    = 1'b0;
    for (int i = 0; i < `SCAN_NUM_STREAMS; i++)
    begin
      m_state[i]  = '0;
      m_saved[i]  = 1'b0;
      m_enable[i] = 1'b0;
    end
    m_count   = '0;
    exp_count = '0;
    exp_flag  = 1'b0;
    exp_hold  = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_begin("reset and disabled stream");
    add_text("xxfingerxx");
    run_packet(3, 1'b1);
    test_end();

    test_begin("single packet match");
    cfg_write(1, 1'b1);
    add_filler(5);
    add_text("finger");
    add_filler(4);
    run_packet(1, 1'b1);
    add_text("xxfingexx");
    run_packet(1, 1'b0);
    test_end();

    test_begin("split keyword");
    cfg_write(5, 1'b1);
    add_text("xxfing");
    run_packet(5, 1'b1);
    add_text("erxx");
    run_packet(5, 1'b0);
    // Same split, second part on a fresh stream
    add_text("xxfing");
    run_packet(5, 1'b0);
    add_text("erxx");
    run_packet(5, 1'b1);
    test_end();

    test_begin("disabled stream");
    cfg_write(7, 1'b1);
    add_text("xxxx");
    run_packet(7, 1'b1);
    cfg_write(7, 1'b0);
    add_text("xfingerx");
    run_packet(7, 1'b0);
    add_text("fin");
    run_packet(7, 1'b0);
    add_text("ger");
    run_packet(7, 1'b0);
    test_end();

    test_begin("interleaved streams");
    cfg_write(20, 1'b1);
    cfg_write(21, 1'b1);
    cfg_write(22, 1'b1);
    add_text("xfi");
    run_packet(20, 1'b1);
    add_text("fing");
    run_packet(21, 1'b1);
    add_text("f");
    run_packet(22, 1'b1);
    add_text("nge");
    run_packet(20, 1'b0);
    add_text("er");
    run_packet(21, 1'b0);
    add_text("ix");
    run_packet(22, 1'b0);
    add_text("r");
    run_packet(20, 1'b0);
    test_end();

    test_begin("random packets");
    for (int i = 0; i < 4; i++)
      cfg_write(scan_pkg::stream_id_t'(40 + i), 1'b1);
    for (int p = 0; p < 40; p++)
    begin
      draw_bits(2, r);
      if (r == 0)
      begin
        draw_bits(4, r);
        cfg_write(scan_pkg::stream_id_t'(40 + r[2:0]), r[3]);
      end
      draw_bits(3, r);
      sid = scan_pkg::stream_id_t'(40 + r[2:0]);
      // Memory of a stream is only known once it was saved
      draw_bits(3, r);
      is_new = !m_saved[sid] || (r == 0);
      draw_bits(4, r);
      add_filler(1 + r);
      draw_bits(2, r);
      if (r == 0)
        add_text("fin");
      else if (r == 1)
        add_text("ger");
      draw_bits(3, r);
      add_filler(r);
      run_packet(sid, is_new);
    end
    test_end();

    $display("Tests run %0d, tests failed %0d, errors %0d", test_num, tests_failed,
             error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
scan_pkg.sv
keyword_dfa.sv
stream_matcher.sv
stream_enable_regs.sv
stream_scanner_top.sv
tb_stream_scanner.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stream_scanner -f verilog.f \
  && ./obj_dir/Vtb_stream_scanner | tee sim.log \
  || { echo "Simulation build or run failed"; exit 1; }

grep -qx "Finished with no errors" sim.log \
  && { echo "Result PASS"; exit 0; } \
  || { echo "Result FAIL"; exit 1; }
